//--- rv_exec_top.f
+incdir+src
src/rv_exec_pkg.sv
src/rv_decoder.sv
src/rv_reg_file.sv
src/rv_exec_unit.sv
src/rv_lsu.sv
src/rv_mem_arbiter.sv
src/rv_data_mem.sv
src/rv_exec_top.sv
testbench/rv_exec_checker.sv
testbench/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - src
    files:
      - src/rv_exec_pkg.sv
      - src/rv_decoder.sv
      - src/rv_reg_file.sv
      - src/rv_exec_unit.sv
      - src/rv_lsu.sv
      - src/rv_mem_arbiter.sv
      - src/rv_data_mem.sv
      - src/rv_exec_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/rv_exec_checker.sv
      - testbench/rv_exec_tb.sv

//--- testbench/rv_exec_tb.sv
`timescale 1ns/1ns
`include "rv_exec_settings.svh"

module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam logic [6:0] OPC_OP    = 7'h33;
    localparam logic [6:0] OPC_OP32  = 7'h3b;
    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_LOAD  = 7'h03;
    localparam logic [6:0] OPC_STORE = 7'h23;
    localparam logic [6:0] OPC_JALR  = 7'h67;
    localparam int         TIMEOUT   = 40;    // cycles per wait

    logic             clk;
    logic             rst_n;
    logic             inst_valid;
    inst_u            inst;
    logic             busy;
    logic             retire;
    logic             illegal;
    logic [`XLEN-1:0] pc;
    mem_req_t         host_req;
    mem_rsp_t         host_rsp;

    logic [`XLEN-1:0] m_regs [32];           // model state
    logic [`XLEN-1:0] m_mem [`MEM_DEPTH];
    logic [`XLEN-1:0] m_pc = '0;
    logic             exp_ill_q [$];
    logic [`XLEN-1:0] exp_pc_q [$];
    logic [`XLEN-1:0] exp_pc;
    logic             exp_ill;
    logic             pc_due = 1'b0;
    int               errors = 0;
    int               checks = 0;
    int               seed = 32'h2739_804f;

    rv_exec_top rv_exec_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .busy       (busy),
        .retire     (retire),
        .illegal    (illegal),
        .pc         (pc),
        .host_req   (host_req),
        .host_rsp   (host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    // updates the model for one instruction and returns 1 if it is unsupported
    function automatic logic ref_exec(input logic [31:0] w);
        logic [4:0]       rd;
        logic [2:0]       f3;
        logic [6:0]       opc;
        logic [63:0]      a;
        logic [63:0]      b;
        logic [63:0]      imm_i;
        logic [63:0]      imm_s;
        logic [63:0]      addr;
        logic [63:0]      res;
        logic [63:0]      next_pc;
        logic [31:0]      s32;
        logic [`MEM_ADDR_W-1:0] idx;
        logic             wr;
        logic             bad;
        opc     = w[6:0];
        rd      = w[11:7];
        f3      = w[14:12];
        a       = m_regs[w[19:15]];
        b       = m_regs[w[24:20]];
        imm_i   = {{52{w[31]}}, w[31:20]};
        imm_s   = {{52{w[31]}}, w[31:25], w[11:7]};
        wr      = 1'b0;
        bad     = 1'b0;
        res     = '0;
        next_pc = m_pc + 64'd4;
        if (opc == OPC_OP && f3 == 3'd0 && w[31:25] == 7'd0) begin
            res = a + b;
            wr  = 1'b1;
        end else if (opc == OPC_OP32 && f3 == 3'd0 && w[31:25] == 7'd0) begin
            s32 = a[31:0] + b[31:0];
            res = {{32{s32[31]}}, s32};
            wr  = 1'b1;
        end else if (opc == OPC_IMM && f3 == 3'd0) begin
            res = a + imm_i;
            wr  = 1'b1;
        end else if (opc == OPC_LOAD && (f3 == 3'd2 || f3 == 3'd3)) begin
            addr = a + imm_i;
            idx  = addr[3 +: `MEM_ADDR_W];                   // wraps at memory end
            s32  = addr[2] ? m_mem[idx][63:32] : m_mem[idx][31:0];
            res  = (f3 == 3'd2) ? {{32{s32[31]}}, s32} : m_mem[idx];
            wr   = 1'b1;
        end else if (opc == OPC_STORE && (f3 == 3'd2 || f3 == 3'd3)) begin
            addr = a + imm_s;
            idx  = addr[3 +: `MEM_ADDR_W];
            if (f3 == 3'd3)
                m_mem[idx] = b;
            else if (addr[2])
                m_mem[idx][63:32] = b[31:0];
            else
                m_mem[idx][31:0] = b[31:0];
        end else if (opc == OPC_JALR && f3 == 3'd0) begin
            res     = m_pc + 64'd4;
            wr      = 1'b1;
            next_pc = (a + imm_i) & ~64'd1;
        end else begin
            bad = 1'b1;
        end
        if (wr && rd != 5'd0) m_regs[rd] = res;
        m_pc = next_pc;
        return bad;
    endfunction

    // busy holds from the cycle after acceptance through retire
    task automatic check_busy_high();
        checks++;
        if (busy !== 1'b1) begin
            errors++;
            $display("MISMATCH t=%0t busy expected=1 actual=%b", $time, busy);
        end
    endtask

    task automatic execute(input logic [31:0] w);
        int   n;
        logic ill;
        n = 0;
        @(negedge clk);
        while (busy !== 1'b0) begin
            n++;
            if (n > TIMEOUT) begin
                errors++;
                $display("busy never dropped before issuing %h at %0t", w, $time);
                return;
            end
            @(negedge clk);
        end
        ill = ref_exec(w);
        exp_ill_q.push_back(ill);
        exp_pc_q.push_back(m_pc);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        @(posedge clk);                          // accepting edge
        inst_valid <= 1'b0;
        n = 0;
        @(negedge clk);
        check_busy_high();
        while (retire !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                errors++;
                $display("instruction %h never retired, stopped waiting at %0t", w, $time);
                return;
            end
            @(negedge clk);
            check_busy_high();
        end
    endtask

    task automatic host_access(input logic we, input logic [`MEM_ADDR_W-1:0] idx,
                               input logic [`XLEN-1:0] wdata);
        int               n;
        logic [`XLEN-1:0] rdata;
        mem_req_t         r;
        r.req   = 1'b1;
        r.we    = we;
        r.addr  = idx;
        r.wdata = wdata;
        r.wmask = 8'hff;
        @(posedge clk);
        host_req <= r;
        n = 0;
        @(negedge clk);
        while (host_rsp.ack !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                errors++;
                $display("host access to index %0d got no ack by %0t", idx, $time);
                @(posedge clk);
                host_req <= '0;
                return;
            end
            @(negedge clk);
        end
        rdata = host_rsp.rdata;
        @(posedge clk);
        host_req <= '0;
        if (we) begin
            m_mem[idx] = wdata;
        end else begin
            checks++;
            if (rdata !== m_mem[idx]) begin
                errors++;
                $display("MISMATCH t=%0t host_rsp.rdata[%0d] expected=%h actual=%h",
                         $time, idx, m_mem[idx], rdata);
            end
        end
    endtask

    // pc is checked one cycle after retire
    always @(negedge clk) begin
        if (rst_n) begin
            if (pc_due) begin
                pc_due = 1'b0;
                checks++;
                if (pc !== exp_pc) begin
                    errors++;
                    $display("MISMATCH t=%0t pc expected=%h actual=%h", $time, exp_pc, pc);
                end
            end
            if (retire === 1'b1) begin
                if (exp_ill_q.size() == 0) begin
                    errors++;
                    $display("retire pulse with no instruction issued at %0t", $time);
                end else begin
                    exp_ill = exp_ill_q.pop_front();
                    exp_pc  = exp_pc_q.pop_front();
                    pc_due  = 1'b1;
                    checks++;
                    if (illegal !== exp_ill) begin
                        errors++;
                        $display("MISMATCH t=%0t illegal expected=%b actual=%b",
                                 $time, exp_ill, illegal);
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        host_req   = '0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // host fills the whole memory then reads back at random
        for (int i = 0; i < `MEM_DEPTH; i++) host_access(1'b1, i, {$random(seed), $random(seed)});
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            host_access(1'b0, r[`MEM_ADDR_W-1:0], '0);
        end

        // adds, 32-bit overflow, x0 writes
        for (int i = 1; i < 32; i++) begin
            r = $random(seed);
            execute(i_word(r[11:0], 5'd0, 3'd0, 5'(i), OPC_IMM));
        end
        execute(i_word(12'h7ff, 5'd0, 3'd0, 5'd5, OPC_IMM));
        repeat (20) execute(r_word(7'd0, 5'd5, 5'd5, 3'd0, 5'd5, OPC_OP));
        execute(r_word(7'd0, 5'd5, 5'd5, 3'd0, 5'd6, OPC_OP32));   // wraps past bit 31
        execute(r_word(7'd0, 5'd5, 5'd5, 3'd0, 5'd0, OPC_OP32));
        execute(r_word(7'd0, 5'd5, 5'd5, 3'd0, 5'd7, OPC_OP));
        execute(i_word(12'h123, 5'd5, 3'd0, 5'd0, OPC_IMM));
        for (int k = 0; k < 40; k++) begin
            r = $random(seed);
            w = $random(seed);
            case (r[1:0])
                2'd0:    execute(i_word(w[31:20], r[9:5], 3'd0, r[14:10], OPC_IMM));
                2'd1:    execute(r_word(7'd0, r[19:15], r[9:5], 3'd0, r[14:10], OPC_OP));
                default: execute(r_word(7'd0, r[19:15], r[9:5], 3'd0, r[14:10], OPC_OP32));
            endcase
        end
        for (int i = 0; i < 32; i++) execute(s_word(12'(8 * i), 5'(i), 5'd0, 3'd3));
        for (int i = 0; i < 32; i++) host_access(1'b0, i, '0);

        // loads with and without bit 31 set
        host_access(1'b1, 8'd40, 64'h8123_4567_7edc_ba98);
        host_access(1'b1, 8'd41, 64'h0123_4567_fedc_ba98);
        execute(i_word(12'd320, 5'd0, 3'd0, 5'd20, OPC_IMM));
        execute(i_word(12'd320, 5'd0, 3'd2, 5'd8, OPC_LOAD));
        execute(i_word(12'd324, 5'd0, 3'd2, 5'd9, OPC_LOAD));      // negative word
        execute(i_word(12'd328, 5'd0, 3'd2, 5'd10, OPC_LOAD));
        execute(i_word(12'd320, 5'd0, 3'd3, 5'd11, OPC_LOAD));
        execute(i_word(12'd8, 5'd20, 3'd3, 5'd12, OPC_LOAD));
        execute(i_word(12'd12, 5'd20, 3'd2, 5'd13, OPC_LOAD));
        for (int i = 8; i < 14; i++) execute(s_word(12'(8 * (34 + i)), 5'(i), 5'd0, 3'd3));
        for (int i = 42; i < 48; i++) host_access(1'b0, i, '0);

        // word stores into each half
        host_access(1'b1, 8'd50, 64'h1111_2222_3333_4444);
        host_access(1'b1, 8'd51, 64'h5555_6666_7777_8888);
        execute(i_word(12'hfff, 5'd0, 3'd0, 5'd14, OPC_IMM));
        execute(s_word(12'd400, 5'd14, 5'd0, 3'd2));
        execute(s_word(12'd412, 5'd7, 5'd0, 3'd2));
        host_access(1'b0, 8'd50, '0);
        host_access(1'b0, 8'd51, '0);

        // jalr to an odd target with the link checked through a store
        execute(i_word(12'h101, 5'd0, 3'd0, 5'd15, OPC_IMM));
        execute(i_word(12'h020, 5'd15, 3'd0, 5'd16, OPC_JALR));
        execute(s_word(12'd416, 5'd16, 5'd0, 3'd3));
        host_access(1'b0, 8'd52, '0);

        // host traffic while a load or store runs
        fork
            execute(s_word(12'd504, 5'd5, 5'd0, 3'd3));
            host_access(1'b0, 8'd5, '0);
        join
        fork
            execute(i_word(12'd480, 5'd0, 3'd3, 5'd17, OPC_LOAD));
            host_access(1'b1, 8'd61, 64'hdead_beef_0bad_f00d);
        join
        execute(s_word(12'd496, 5'd17, 5'd0, 3'd3));
        host_access(1'b0, 8'd61, '0);
        host_access(1'b0, 8'd62, '0);
        host_access(1'b0, 8'd63, '0);

        // unsupported opcodes including sub
        execute(32'h0000_0000);
        execute(r_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP));
        execute(s_word(12'd504, 5'd3, 5'd0, 3'd3));
        host_access(1'b0, 8'd63, '0);

        repeat (3) @(negedge clk);
        if (exp_ill_q.size() != 0) begin
            errors++;
            $display("%0d issued instructions never retired", exp_ill_q.size());
        end
        errors += rv_exec_top_i.rv_exec_checker_i.fail_count;
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- testbench/rv_exec_checker.sv
`timescale 1ns/1ns

module rv_exec_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  inst_valid,
    input logic                  busy,
    input logic                  retire,
    input logic                  illegal,
    input rv_exec_pkg::mem_req_t host_req,
    input rv_exec_pkg::mem_rsp_t host_rsp,
    input rv_exec_pkg::mem_req_t lsu_req,
    input rv_exec_pkg::mem_rsp_t lsu_rsp
);

    int fail_count = 0;  // failed assertions

    // retire is the last busy cycle of an instruction
    retire_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        retire |-> busy ##1 !busy)
        else begin
            fail_count++;
            $error("retire outside busy or busy still high after retire");
        end

    illegal_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> busy && $past(inst_valid && !busy))
        else begin
            fail_count++;
            $error("illegal outside busy or not one cycle after acceptance");
        end

    // host holds its request until the ack cycle
    host_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        host_req.req && !host_rsp.ack |=> $stable(host_req))
        else begin
            fail_count++;
            $error("host request changed before its ack");
        end

    host_ack_pending: assert property (@(posedge clk) disable iff (!rst_n)
        host_rsp.ack |-> host_req.req)
        else begin
            fail_count++;
            $error("host ack without a pending host request");
        end

    lsu_ack_pending: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rsp.ack |-> lsu_req.req)
        else begin
            fail_count++;
            $error("load/store ack without a pending request");
        end

endmodule

bind rv_exec_top rv_exec_checker rv_exec_checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .busy       (busy),
    .retire     (retire),
    .illegal    (illegal),
    .host_req   (host_req),
    .host_rsp   (host_rsp),
    .lsu_req    (lsu_req),
    .lsu_rsp    (lsu_rsp)
);

//--- src/rv_exec_top.sv
`timescale 1ns/1ns
`include "rv_exec_settings.svh"

module rv_exec_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  rv_exec_pkg::inst_u    inst,
    output logic                  busy,
    output logic                  retire,
    output logic                  illegal,
    output logic [`XLEN-1:0]      pc,
    input  rv_exec_pkg::mem_req_t host_req,
    output rv_exec_pkg::mem_rsp_t host_rsp
);
    import rv_exec_pkg::*;

    uop_t                   uop;
    logic [`REG_ADDR_W-1:0] rf_raddr1;
    logic [`REG_ADDR_W-1:0] rf_raddr2;
    logic [`XLEN-1:0]       rf_rdata1;
    logic [`XLEN-1:0]       rf_rdata2;
    logic                   rf_wen;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]       rf_wdata;
    logic                   lsu_start;
    op_e                    lsu_op;
    logic [`XLEN-1:0]       lsu_base;
    logic [`XLEN-1:0]       lsu_store_data;
    logic [`XLEN-1:0]       lsu_imm;
    logic                   lsu_done;
    logic [`XLEN-1:0]       lsu_load_data;
    mem_req_t               lsu_req;
    mem_rsp_t               lsu_rsp;
    mem_req_t               mem_req;
    mem_rsp_t               mem_rsp;

    rv_decoder rv_decoder_i (
        .inst (inst),
        .uop  (uop)
    );

    rv_reg_file rv_reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    rv_exec_unit rv_exec_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .uop            (uop),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .rf_wen         (rf_wen),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .lsu_start      (lsu_start),
        .lsu_op         (lsu_op),
        .lsu_base       (lsu_base),
        .lsu_store_data (lsu_store_data),
        .lsu_imm        (lsu_imm),
        .lsu_done       (lsu_done),
        .lsu_load_data  (lsu_load_data),
        .busy           (busy),
        .retire         (retire),
        .illegal        (illegal),
        .pc             (pc)
    );

    rv_lsu rv_lsu_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (lsu_start),
        .op         (lsu_op),
        .base       (lsu_base),
        .store_data (lsu_store_data),
        .imm        (lsu_imm),
        .done       (lsu_done),
        .load_data  (lsu_load_data),
        .mem_req    (lsu_req),
        .mem_rsp    (lsu_rsp)
    );

    rv_mem_arbiter rv_mem_arbiter_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .lsu_req  (lsu_req),
        .lsu_rsp  (lsu_rsp),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    rv_data_mem rv_data_mem_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

//--- src/rv_data_mem.sv
`timescale 1ns/1ns
`include "rv_exec_settings.svh"

module rv_data_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_exec_pkg::mem_req_t req,
    output rv_exec_pkg::mem_rsp_t rsp
);

    logic [`XLEN-1:0] mem [`MEM_DEPTH];
    logic             ack_q;
    logic [`XLEN-1:0] rdata_q;

    always_ff @(posedge clk) begin
        if (req.req && req.we) begin
            for (int b = 0; b < `XLEN / 8; b++) begin
                if (req.wmask[b]) mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
        if (req.req) rdata_q <= mem[req.addr];   // old data on a write
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= req.req;
    end

    assign rsp.ack   = ack_q;
    assign rsp.rdata = rdata_q;

endmodule

//--- src/rv_mem_arbiter.sv
`timescale 1ns/1ns

module rv_mem_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_exec_pkg::mem_req_t lsu_req,
    output rv_exec_pkg::mem_rsp_t lsu_rsp,
    input  rv_exec_pkg::mem_req_t host_req,
    output rv_exec_pkg::mem_rsp_t host_rsp,
    output rv_exec_pkg::mem_req_t mem_req,
    input  rv_exec_pkg::mem_rsp_t mem_rsp
);
    import rv_exec_pkg::*;

    typedef enum logic [1:0] {OWN_NONE, OWN_LSU, OWN_HOST} owner_e;

    owner_e   owner;
    mem_req_t fwd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (lsu_req.req)
                        owner <= OWN_LSU;       // lsu wins a tie
                    else if (host_req.req)
                        owner <= OWN_HOST;
                end
                default: begin
                    if (mem_rsp.ack) owner <= OWN_NONE;
                end
            endcase
        end
    end

    always_comb begin
        case (owner)
            OWN_LSU:  fwd = lsu_req;
            OWN_HOST: fwd = host_req;
            default:  fwd = '0;
        endcase
    end

    // req drops in the ack cycle so each grant makes one request
    always_comb begin
        mem_req     = fwd;
        mem_req.req = fwd.req && !mem_rsp.ack;
    end

    assign lsu_rsp.ack    = (owner == OWN_LSU) && mem_rsp.ack;
    assign lsu_rsp.rdata  = (owner == OWN_LSU) ? mem_rsp.rdata : '0;
    assign host_rsp.ack   = (owner == OWN_HOST) && mem_rsp.ack;
    assign host_rsp.rdata = (owner == OWN_HOST) ? mem_rsp.rdata : '0;

endmodule

//--- src/rv_lsu.sv
`timescale 1ns/1ns
`include "rv_exec_settings.svh"

module rv_lsu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  rv_exec_pkg::op_e      op,
    input  logic [`XLEN-1:0]      base,
    input  logic [`XLEN-1:0]      store_data,
    input  logic [`XLEN-1:0]      imm,
    output logic                  done,
    output logic [`XLEN-1:0]      load_data,
    output rv_exec_pkg::mem_req_t mem_req,
    input  rv_exec_pkg::mem_rsp_t mem_rsp
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0]       byte_addr;
    logic                   is_store;
    logic                   half;
    logic [7:0]             mask_nxt;
    logic [`XLEN-1:0]       wdata_nxt;
    logic [31:0]            word;

    logic                   req_q;
    logic                   we_q;
    logic                   half_q;    // upper word selected
    logic [`MEM_ADDR_W-1:0] addr_q;
    logic [`XLEN-1:0]       wdata_q;
    logic [7:0]             wmask_q;

    assign byte_addr = base + imm;
    assign half      = byte_addr[2];
    assign is_store  = (op == OP_SW) || (op == OP_SD);

    always_comb begin
        if (op == OP_SW) begin
            mask_nxt  = half ? 8'hf0 : 8'h0f;
            wdata_nxt = half ? {store_data[31:0], 32'h0} : {32'h0, store_data[31:0]};
        end else begin
            mask_nxt  = 8'hff;
            wdata_nxt = store_data;
        end
    end

    // request level held until ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            req_q <= 1'b0;
        else if (req_q && mem_rsp.ack)
            req_q <= 1'b0;
        else if (start && !req_q)
            req_q <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (start && !req_q) begin
            we_q    <= is_store;
            half_q  <= half;
            addr_q  <= byte_addr[3 +: `MEM_ADDR_W];   // wraps at MEM_DEPTH
            wdata_q <= wdata_nxt;
            wmask_q <= mask_nxt;
        end
    end

    assign mem_req.req   = req_q;
    assign mem_req.we    = we_q;
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = wdata_q;
    assign mem_req.wmask = wmask_q;

    assign done = req_q && mem_rsp.ack;
    assign word = half_q ? mem_rsp.rdata[63:32] : mem_rsp.rdata[31:0];

    always_comb begin
        if (op == OP_LW)
            load_data = {{(`XLEN-32){word[31]}}, word};
        else
            load_data = mem_rsp.rdata;
    end

endmodule

//--- src/rv_exec_unit.sv
`timescale 1ns/1ns
`include "rv_exec_settings.svh"

module rv_exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  rv_exec_pkg::uop_t      uop,
    output logic [`REG_ADDR_W-1:0] rf_raddr1,
    output logic [`REG_ADDR_W-1:0] rf_raddr2,
    input  logic [`XLEN-1:0]       rf_rdata1,
    input  logic [`XLEN-1:0]       rf_rdata2,
    output logic                   rf_wen,
    output logic [`REG_ADDR_W-1:0] rf_waddr,
    output logic [`XLEN-1:0]       rf_wdata,
    output logic                   lsu_start,
    output rv_exec_pkg::op_e       lsu_op,
    output logic [`XLEN-1:0]       lsu_base,
    output logic [`XLEN-1:0]       lsu_store_data,
    output logic [`XLEN-1:0]       lsu_imm,
    input  logic                   lsu_done,
    input  logic [`XLEN-1:0]       lsu_load_data,
    output logic                   busy,
    output logic                   retire,
    output logic                   illegal,
    output logic [`XLEN-1:0]       pc
);
    import rv_exec_pkg::*;

    typedef enum logic {S_IDLE, S_WAIT_MEM} state_e;

    state_e           state;
    uop_t             uop_q;
    logic             alu_q;       // execute slot of a non-memory op
    logic             mem_ret_q;   // retire slot of a load or store
    logic             accept;
    logic             accept_mem;
    logic             mem_done;
    logic             q_is_load;
    logic [31:0]      sum_w;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] pc_plus4;

    assign accept     = inst_valid && !busy;
    assign accept_mem = uop.op inside {OP_LW, OP_LD, OP_SW, OP_SD};
    assign mem_done   = (state == S_WAIT_MEM) && lsu_done;
    assign q_is_load  = uop_q.op inside {OP_LW, OP_LD};
    assign sum_w      = rf_rdata1[31:0] + rf_rdata2[31:0];
    assign jalr_sum   = rf_rdata1 + uop_q.imm;
    assign pc_plus4   = pc + `XLEN'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            alu_q     <= 1'b0;
            mem_ret_q <= 1'b0;
        end else begin
            alu_q     <= accept && !accept_mem;
            mem_ret_q <= mem_done;
            if (accept && accept_mem)
                state <= S_WAIT_MEM;
            else if (mem_done)
                state <= S_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) uop_q <= uop;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= '0;
        else if (alu_q && uop_q.op == OP_JALR)
            pc <= {jalr_sum[`XLEN-1:1], 1'b0};     // bit 0 cleared
        else if (alu_q || mem_done)
            pc <= pc_plus4;                         // illegal advances too
    end

    always_comb begin
        case (uop_q.op)
            OP_ADD:  rf_wdata = rf_rdata1 + rf_rdata2;
            OP_ADDI: rf_wdata = jalr_sum;           // same adder as jalr
            OP_ADDW: rf_wdata = {{(`XLEN-32){sum_w[31]}}, sum_w};
            OP_JALR: rf_wdata = pc_plus4;           // link value
            default: rf_wdata = lsu_load_data;
        endcase
    end

    assign rf_raddr1 = uop_q.rs1;
    assign rf_raddr2 = uop_q.rs2;
    assign rf_waddr  = uop_q.rd;
    assign rf_wen    = (alu_q && (uop_q.op inside {OP_ADD, OP_ADDW, OP_ADDI, OP_JALR}))
                     || (mem_done && q_is_load);

    assign lsu_start      = (state == S_WAIT_MEM);
    assign lsu_op         = uop_q.op;
    assign lsu_base       = rf_rdata1;
    assign lsu_store_data = rf_rdata2;
    assign lsu_imm        = uop_q.imm;

    assign busy    = alu_q || (state == S_WAIT_MEM) || mem_ret_q;
    assign retire  = alu_q || mem_ret_q;
    assign illegal = alu_q && (uop_q.op == OP_ILLEGAL);

endmodule

//--- src/rv_reg_file.sv
`timescale 1ns/1ns
`include "rv_exec_settings.svh"

module rv_reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wen,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // writes to x0 dropped
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (raddr1 == '0)
            rdata1 = '0;
        else
            rdata1 = regs[raddr1];
    end

    always_comb begin
        if (raddr2 == '0)
            rdata2 = '0;
        else
            rdata2 = regs[raddr2];
    end

endmodule

//--- src/rv_decoder.sv
`timescale 1ns/1ns
`include "rv_exec_settings.svh"

module rv_decoder (
    input  rv_exec_pkg::inst_u inst,
    output rv_exec_pkg::uop_t  uop
);
    import rv_exec_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_32  = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic             f7_zero;

    assign imm_i   = {{(`XLEN-12){inst.i_view.imm[11]}}, inst.i_view.imm};
    assign imm_s   = {{(`XLEN-12){inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi,
                      inst.s_view.imm_lo};
    assign f7_zero = (inst.r_view.funct7 == 7'b0);

    always_comb begin
        uop.op  = OP_ILLEGAL;
        uop.rd  = inst.r_view.rd;
        uop.rs1 = inst.r_view.rs1;
        uop.rs2 = inst.r_view.rs2;
        uop.imm = imm_i;                        // I format unless a store
        case (inst.r_view.opcode)
            OPC_OP: begin
                if (inst.r_view.funct3 == 3'b000 && f7_zero) uop.op = OP_ADD;
            end
            OPC_OP_32: begin
                if (inst.r_view.funct3 == 3'b000 && f7_zero) uop.op = OP_ADDW;
            end
            OPC_OP_IMM: begin
                if (inst.r_view.funct3 == 3'b000) uop.op = OP_ADDI;
            end
            OPC_LOAD: begin
                if (inst.r_view.funct3 == 3'b010) uop.op = OP_LW;
                else if (inst.r_view.funct3 == 3'b011) uop.op = OP_LD;
            end
            OPC_STORE: begin
                uop.imm = imm_s;
                if (inst.r_view.funct3 == 3'b010) uop.op = OP_SW;
                else if (inst.r_view.funct3 == 3'b011) uop.op = OP_SD;
            end
            OPC_JALR: begin
                if (inst.r_view.funct3 == 3'b000) uop.op = OP_JALR;
            end
            default: uop.op = OP_ILLEGAL;
        endcase
    end

endmodule

//--- src/rv_exec_pkg.sv
`include "rv_exec_settings.svh"

package rv_exec_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        logic [6:0] opcode;
    } s_view_t;

    // same 32-bit word, decoded per format
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        s_view_t s_view;
    } inst_u;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_ADDW,
        OP_ADDI,
        OP_LW,
        OP_LD,
        OP_SW,
        OP_SD,
        OP_JALR,
        OP_ILLEGAL
    } op_e;

    typedef struct packed {
        op_e                   op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;   // already sign-extended
    } uop_t;

    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`MEM_ADDR_W-1:0] addr;  // doubleword index
        logic [`XLEN-1:0]       wdata;
        logic [7:0]             wmask;
    } mem_req_t;

    typedef struct packed {
        logic             ack;
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

//--- src/rv_exec_settings.svh
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// integer register and datapath width
`define XLEN 64

// 32 architectural registers
`define REG_ADDR_W 5

// data memory size in doublewords
`define MEM_DEPTH 256

// log2 of MEM_DEPTH, doubleword index
`define MEM_ADDR_W 8

`endif
